//--- filelist.f
+incdir+source
+incdir+tests
source/hybridPkg.sv
source/sampleWindow.sv
source/lookaheadFir.sv
source/poleLane.sv
source/lookbackBank.sv
source/outputCombiner.sv
source/hybridDecimator.sv
tests/hybridDecimatorTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP := hybridDecimatorTb
FILELIST := filelist.f
OBJDIR := obj_dir
SIM := $(OBJDIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh tests/*.sv tests/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJDIR)

//--- tests/hybridModel.svh
`ifndef HYBRIDMODEL_SVH
`define HYBRIDMODEL_SVH

// Bit history, newest bit at index 0
logic [`DSR+`LOOKAHEAD-1:0] histBits;
int phaseCount;
int blocksDone;
int expPulses;
int satWords;
longint poleRe [`POLES];
longint poleIm [`POLES];
logic [`OUT_WIDTH-1:0] expWords [$];
int expDue [$];

// Keep only the accumulator width, sign extended
function automatic longint wrapAcc(input longint v);
    logic signed [`ACC_WIDTH-1:0] t;
    t = v[`ACC_WIDTH-1:0];
    return longint'(t);
endfunction

function automatic longint bitSign(input logic b);
    return b ? 64'sd1 : -64'sd1;
endfunction

// Closes a reset segment and clears the history and pole states
task automatic resetModel();
    if (blocksDone >= `WARMUP_BLOCKS)
        expPulses += blocksDone - `WARMUP_BLOCKS + 1;
    histBits = '0;
    phaseCount = 0;
    blocksDone = 0;
    for (int p = 0; p < `POLES; p++) begin
        poleRe[p] = 0;
        poleIm[p] = 0;
    end
endtask

task automatic blockWord(input int dueCycle);
    longint fir;
    longint back;
    longint pRe;
    longint pIm;
    longint nRe;
    longint nIm;
    longint total;
    longint maxCode;
    longint biased;
    fir = 0;
    back = 0;
    maxCode = (64'sd1 <<< (`OUT_WIDTH - 1)) - 1;
    for (int i = 0; i < `LOOKAHEAD; i++)
        fir += longint'(hbCoef[i]) * bitSign(histBits[`LOOKAHEAD-1-i]);
    for (int p = 0; p < `POLES; p++) begin
        pRe = 0;
        pIm = 0;
        // Oldest bit of the block first
        for (int i = 0; i < `DSR; i++) begin
            pRe += longint'(ffRe[p][i]) * bitSign(histBits[`DSR+`LOOKAHEAD-1-i]);
            pIm += longint'(ffIm[p][i]) * bitSign(histBits[`DSR+`LOOKAHEAD-1-i]);
        end
        nRe = longint'(lfRe[p]) * poleRe[p] - longint'(lfIm[p]) * poleIm[p];
        nIm = longint'(lfRe[p]) * poleIm[p] + longint'(lfIm[p]) * poleRe[p];
        poleRe[p] = wrapAcc(wrapAcc(nRe >>> `FRAC) + wrapAcc(pRe));
        poleIm[p] = wrapAcc(wrapAcc(nIm >>> `FRAC) + wrapAcc(pIm));
        nRe = longint'(wfRe[p]) * poleRe[p] - longint'(wfIm[p]) * poleIm[p];
        back += wrapAcc(nRe >>> `FRAC);
    end
    total = (wrapAcc(fir) + wrapAcc(back)) >>> `OUT_SHIFT;
    if (total > maxCode) begin
        total = maxCode;
        satWords++;
    end else if (total < -maxCode - 1) begin
        total = -maxCode - 1;
        satWords++;
    end
    // Offset binary
    biased = total + maxCode + 1;
    expWords.push_back(biased[`OUT_WIDTH-1:0]);
    expDue.push_back(dueCycle);
endtask

task automatic pushBit(input logic b, input int cycleNow);
    histBits = {histBits[`DSR+`LOOKAHEAD-2:0], b};
    phaseCount++;
    if (phaseCount == `DSR) begin
        phaseCount = 0;
        blocksDone++;
        // Pole states stay zero until the window is full
        if (blocksDone >= `WARMUP_BLOCKS)
            blockWord(cycleNow + `LATENCY + 1);
    end
endtask

`endif

//--- tests/hybridDecimatorTb.sv
`timescale 1ns/1ps
`include "hybridDecim_cfg.svh"

module hybridDecimatorTb import hybridPkg::*; ();

    localparam int randBlocks = 400;
    localparam int runBlocks = 40;
    localparam int restartBlocks = 30;
    localparam int resetCycles = 10;
    // Each block takes DSR cycles, with slack for resets and draining
    localparam longint timeLimit =
        longint'((randBlocks + 2 * runBlocks + restartBlocks + 4) * (`DSR + 2)
        + 4 * resetCycles) * 100;

    logic clkDS;
    logic rst;
    logic din;
    logic [`OUT_WIDTH-1:0] pcmOut;
    logic pcmValid;

    logic [31:0] lfsr;
    int cycle;
    int pulses;
    int outErrors;
    int validErrors;
    int otherErrors;

    `include "hybridModel.svh"

    hybridDecimator u_hybridDecimator (
        .clkDS(clkDS),
        .rst(rst),
        .din(din),
        .pcmOut(pcmOut),
        .pcmValid(pcmValid)
    );

    always #50 clkDS = ~clkDS;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic checkOutputs();
        if (pcmValid === 1'b1)
            pulses++;
        if (expDue.size() > 0 && expDue[0] == cycle) begin
            if (pcmValid !== 1'b1) begin
                $display("ERROR pcmValid at cycle %0d: expected 0x1, got 0x%h", cycle, pcmValid);
                validErrors++;
            end
            if (pcmOut !== expWords[0]) begin
                $display("ERROR pcmOut at cycle %0d: expected 0x%h, got 0x%h",
                         cycle, expWords[0], pcmOut);
                outErrors++;
            end
            void'(expDue.pop_front());
            void'(expWords.pop_front());
        end else if (pcmValid !== 1'b0) begin
            $display("ERROR pcmValid at cycle %0d: expected 0x0, got 0x%h", cycle, pcmValid);
            validErrors++;
        end
    endtask

    // Outputs are stable at the falling edge, so check first and then drive
    task automatic driveBit(input logic b);
        @(negedge clkDS);
        cycle++;
        checkOutputs();
        rst = 1'b1;
        din = b;
        pushBit(b, cycle);
    endtask

    task automatic driveRandom(input int bits);
        for (int i = 0; i < bits; i++) begin
            lfsr = lfsrNext(lfsr);
            driveBit(lfsr[0]);
        end
    endtask

    task automatic driveConst(input logic b, input int bits);
        for (int i = 0; i < bits; i++)
            driveBit(b);
    endtask

    task automatic holdReset(input int n);
        if (expDue.size() > 0) begin
            $display("Reset came while %0d output words were still pending", expDue.size());
            otherErrors++;
            expDue.delete();
            expWords.delete();
        end
        resetModel();
        for (int i = 0; i < n; i++) begin
            @(negedge clkDS);
            cycle++;
            checkOutputs();
            rst = 1'b0;
            din = 1'b0;
        end
    endtask

    // Fewer than DSR bits, so no new block completes
    task automatic drainOutputs();
        int guard = 0;
        while (expDue.size() > 0 && guard < `DSR - 1) begin
            lfsr = lfsrNext(lfsr);
            driveBit(lfsr[0]);
            guard++;
        end
        if (expDue.size() > 0) begin
            $display("Output words still pending after the last block");
            otherErrors++;
        end
    endtask

    initial begin
        #(timeLimit);
        $display("Watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clkDS = 1'b0;
        rst = 1'b0;
        din = 1'b0;
        lfsr = 32'he4a3_e0c2;
        holdReset(resetCycles);
        driveRandom(randBlocks * `DSR);
        // Long constant runs toward both output limits
        driveConst(1'b1, runBlocks * `DSR);
        driveConst(1'b0, runBlocks * `DSR);
        // Stop mid block once the last word is out, then reset
        driveRandom(`LATENCY + 1);
        holdReset(3);
        driveRandom(restartBlocks * `DSR);
        drainOutputs();
        resetModel();
        if (pulses != expPulses) begin
            $display("Saw %0d output pulses but %0d blocks should have produced one",
                     pulses, expPulses);
            otherErrors++;
        end
        $display("Errors: pcmOut %0d, pcmValid %0d, other %0d (words %0d, saturated %0d)",
                 outErrors, validErrors, otherErrors, pulses, satWords);
        if (outErrors + validErrors + otherErrors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- source/hybridDecimator.sv
`timescale 1ns/1ps
`include "hybridDecim_cfg.svh"

module hybridDecimator import hybridPkg::*; (
    input  logic                  clkDS,
    input  logic                  rst,
    input  logic                  din,
    output logic [`OUT_WIDTH-1:0] pcmOut,
    output logic                  pcmValid
);

    logic [`DSR-1:0] blockBits;
    logic [`LOOKAHEAD-1:0] aheadBits;
    logic blockTick;
    logic windowFull;
    accT aheadSum;
    accT backSum;

    sampleWindow u_sampleWindow (
        .clkDS(clkDS),
        .rst(rst),
        .din(din),
        .blockBits(blockBits),
        .aheadBits(aheadBits),
        .blockTick(blockTick),
        .windowFull(windowFull)
    );

    // Lookahead part
    lookaheadFir u_lookaheadFir (
        .clkDS(clkDS),
        .rst(rst),
        .aheadBits(aheadBits),
        .blockTick(blockTick),
        .aheadSum(aheadSum)
    );

    // Lookback part
    lookbackBank u_lookbackBank (
        .clkDS(clkDS),
        .rst(rst),
        .blockBits(blockBits),
        .blockTick(blockTick),
        .windowFull(windowFull),
        .backSum(backSum)
    );

    outputCombiner u_outputCombiner (
        .clkDS(clkDS),
        .rst(rst),
        .aheadSum(aheadSum),
        .backSum(backSum),
        .blockTick(blockTick),
        .windowFull(windowFull),
        .pcmOut(pcmOut),
        .pcmValid(pcmValid)
    );

endmodule

//--- source/outputCombiner.sv
`timescale 1ns/1ps
`include "hybridDecim_cfg.svh"

module outputCombiner import hybridPkg::*; (
    input  logic                  clkDS,
    input  logic                  rst,
    input  accT                   aheadSum,
    input  accT                   backSum,
    input  logic                  blockTick,
    input  logic                  windowFull,
    output logic [`OUT_WIDTH-1:0] pcmOut,
    output logic                  pcmValid
);

    // FIR result is ready two cycles before the last stage
    localparam int alignDelay = `LATENCY - 2;
    localparam int sumW = `ACC_WIDTH + 1;
    localparam logic signed [sumW-1:0] maxOut = sumW'((1 << (`OUT_WIDTH - 1)) - 1);
    localparam logic signed [sumW-1:0] minOut = -maxOut - 1;

    accT aheadDly [alignDelay];
    logic [alignDelay:0] tickMark;
    logic signed [sumW-1:0] total;
    logic signed [sumW-1:0] scaled;
    outT satWord;

    always_ff @(posedge clkDS) begin
        aheadDly[0] <= aheadSum;
        for (int i = 1; i < alignDelay; i++) begin
            aheadDly[i] <= aheadDly[i-1];
        end
    end

    always_comb begin
        total = aheadDly[alignDelay-1] + backSum;
        scaled = total >>> `OUT_SHIFT;
        if (scaled > maxOut)
            satWord = outT'(maxOut);
        else if (scaled < minOut)
            satWord = outT'(minOut);
        else
            satWord = outT'(scaled);
    end

    // Marker follows the FIR result through the alignment
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            tickMark <= '0;
            pcmValid <= 1'b0;
        end else begin
            tickMark <= {tickMark[alignDelay-1:0], blockTick & windowFull};
            pcmValid <= tickMark[alignDelay];
        end
    end

    // Offset binary
    always_ff @(posedge clkDS) begin
        if (tickMark[alignDelay])
            pcmOut <= {~satWord[`OUT_WIDTH-1], satWord[`OUT_WIDTH-2:0]};
    end

endmodule

//--- source/lookbackBank.sv
`timescale 1ns/1ps
`include "hybridDecim_cfg.svh"

module lookbackBank import hybridPkg::*; (
    input  logic            clkDS,
    input  logic            rst,
    input  logic [`DSR-1:0] blockBits,
    input  logic            blockTick,
    input  logic            windowFull,
    output accT             backSum
);

    accT laneOut [`POLES];
    accT laneSum;
    logic zeroIn;
    // Tick delayed by one, two and three cycles
    logic [2:0] tickDly;

    // Pole states stay at zero until the window is full
    assign zeroIn = !windowFull;

    for (genvar p = 0; p < `POLES; p++) begin : gLane
        poleLane #(
            .laneIdx(p)
        ) u_poleLane (
            .clkDS(clkDS),
            .rst(rst),
            .blockBits(blockBits),
            .stepTick(blockTick),
            .zeroIn(zeroIn),
            .laneOut(laneOut[p])
        );
    end

    always_comb begin
        laneSum = '0;
        for (int p = 0; p < `POLES; p++) begin
            laneSum = laneSum + laneOut[p];
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            tickDly <= '0;
        end else begin
            tickDly <= {tickDly[1:0], blockTick};
        end
    end

    always_ff @(posedge clkDS) begin
        if (tickDly[2])
            backSum <= laneSum;
    end

endmodule

//--- source/poleLane.sv
`timescale 1ns/1ps
`include "hybridDecim_cfg.svh"

module poleLane import hybridPkg::*; #(
    parameter int laneIdx = 0
) (
    input  logic            clkDS,
    input  logic            rst,
    input  logic [`DSR-1:0] blockBits,
    input  logic            stepTick,
    input  logic            zeroIn,
    output accT             laneOut
);

    localparam int prodW = `COEF_WIDTH + `ACC_WIDTH + 1;

    accT projRe;
    accT projIm;
    accT projReNext;
    accT projImNext;
    accT stateRe;
    accT stateIm;
    accT stateReNext;
    accT stateImNext;
    logic signed [prodW-1:0] poleRe;
    logic signed [prodW-1:0] poleIm;
    logic signed [prodW-1:0] weighted;
    logic tick1;
    logic tick2;

    // Projection of the block onto this lane's rows
    always_comb begin
        projReNext = '0;
        projImNext = '0;
        if (!zeroIn) begin
            for (int i = 0; i < `DSR; i++) begin
                if (blockBits[i]) begin
                    projReNext = projReNext + ffRe[laneIdx][i];
                    projImNext = projImNext + ffIm[laneIdx][i];
                end else begin
                    projReNext = projReNext - ffRe[laneIdx][i];
                    projImNext = projImNext - ffIm[laneIdx][i];
                end
            end
        end
    end

    // Complex pole times state, full width before the shift
    always_comb begin
        poleRe = lfRe[laneIdx] * stateRe - lfIm[laneIdx] * stateIm;
        poleIm = lfRe[laneIdx] * stateIm + lfIm[laneIdx] * stateRe;
        stateReNext = accT'(poleRe >>> `FRAC) + projRe;
        stateImNext = accT'(poleIm >>> `FRAC) + projIm;
    end

    // Only the real part of the weighted state is needed
    assign weighted = wfRe[laneIdx] * stateRe - wfIm[laneIdx] * stateIm;

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            tick1 <= 1'b0;
            tick2 <= 1'b0;
            stateRe <= '0;
            stateIm <= '0;
        end else begin
            tick1 <= stepTick;
            tick2 <= tick1;
            if (tick1) begin
                stateRe <= stateReNext;
                stateIm <= stateImNext;
            end
        end
    end

    always_ff @(posedge clkDS) begin
        if (stepTick) begin
            projRe <= projReNext;
            projIm <= projImNext;
        end
        if (tick2)
            laneOut <= accT'(weighted >>> `FRAC);
    end

endmodule

//--- source/lookaheadFir.sv
`timescale 1ns/1ps
`include "hybridDecim_cfg.svh"

module lookaheadFir import hybridPkg::*; (
    input  logic                  clkDS,
    input  logic                  rst,
    input  logic [`LOOKAHEAD-1:0] aheadBits,
    input  logic                  blockTick,
    output accT                   aheadSum
);

    localparam int groups = `LOOKAHEAD / `LUT_SIZE;
    localparam int lutDepth = 1 << `LUT_SIZE;

    typedef accT lutT [lutDepth];

    // Signed partial sums of one coefficient group, a 0 bit counts as -1
    function automatic lutT buildLut(input int grp);
        lutT tab;
        accT acc;
        for (int s = 0; s < lutDepth; s++) begin
            acc = '0;
            for (int j = 0; j < `LUT_SIZE; j++) begin
                if (((s >> j) & 1) == 1)
                    acc = acc + hbCoef[grp*`LUT_SIZE + j];
                else
                    acc = acc - hbCoef[grp*`LUT_SIZE + j];
            end
            tab[s] = acc;
        end
        return tab;
    endfunction

    accT groupSum [groups];
    accT firSum;

    for (genvar g = 0; g < groups; g++) begin : gLut
        localparam lutT tab = buildLut(g);
        assign groupSum[g] = tab[aheadBits[g*`LUT_SIZE +: `LUT_SIZE]];
    end

    always_comb begin
        firSum = '0;
        for (int g = 0; g < groups; g++) begin
            firSum = firSum + groupSum[g];
        end
    end

    // Sample once per block
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            aheadSum <= '0;
        end else if (blockTick) begin
            aheadSum <= firSum;
        end
    end

endmodule

//--- source/sampleWindow.sv
`timescale 1ns/1ps
`include "hybridDecim_cfg.svh"

module sampleWindow (
    input  logic                  clkDS,
    input  logic                  rst,
    input  logic                  din,
    output logic [`DSR-1:0]       blockBits,
    output logic [`LOOKAHEAD-1:0] aheadBits,
    output logic                  blockTick,
    output logic                  windowFull
);

    localparam int winLen = `DSR + `LOOKAHEAD;
    localparam int phaseW = $clog2(`DSR);
    localparam int blkW = $clog2(`WARMUP_BLOCKS + 1);

    // Newest bit at index 0
    logic [winLen-1:0] window;
    logic [phaseW-1:0] phase;
    logic [blkW-1:0] blockCount;
    logic lastBit;

    assign lastBit = (phase == phaseW'(`DSR - 1));

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            window <= '0;
            phase <= '0;
            blockTick <= 1'b0;
            blockCount <= '0;
            windowFull <= 1'b0;
        end else begin
            window <= {window[winLen-2:0], din};
            blockTick <= lastBit;
            phase <= lastBit ? '0 : phase + 1'b1;
            // Count blocks only until the window holds real data
            if (lastBit && !windowFull) begin
                blockCount <= blockCount + 1'b1;
                if (blockCount == blkW'(`WARMUP_BLOCKS - 1))
                    windowFull <= 1'b1;
            end
        end
    end

    for (genvar i = 0; i < `DSR; i++) begin : gBlock
        assign blockBits[i] = window[winLen-1-i];
    end

    for (genvar i = 0; i < `LOOKAHEAD; i++) begin : gAhead
        assign aheadBits[i] = window[`LOOKAHEAD-1-i];
    end

endmodule

//--- source/hybridPkg.sv
`include "hybridDecim_cfg.svh"

package hybridPkg;

    typedef logic signed [`COEF_WIDTH-1:0] coefT;
    typedef logic signed [`ACC_WIDTH-1:0] accT;
    typedef logic signed [`OUT_WIDTH-1:0] outT;

    // Lookahead FIR, index 0 nearest to the block
    localparam coefT hbCoef [`LOOKAHEAD] = '{
        16'sd2100, 16'sd2600, 16'sd3100, 16'sd3500,
        16'sd3900, 16'sd4200, 16'sd4400, 16'sd4500,
        16'sd4500, 16'sd4400, 16'sd4200, 16'sd3900,
        16'sd3500, 16'sd3100, 16'sd2600, 16'sd2100
    };

    // Block projections, column 0 is the oldest bit
    localparam coefT ffRe [`POLES][`DSR] = '{
        '{16'sd310, 16'sd420, 16'sd560, 16'sd700, 16'sd820, 16'sd910, 16'sd980, 16'sd1020},
        '{16'sd640, 16'sd520, 16'sd380, 16'sd220, 16'sd60, -16'sd90, -16'sd230, -16'sd350},
        '{-16'sd410, -16'sd180, 16'sd90, 16'sd330, 16'sd510, 16'sd600, 16'sd580, 16'sd470}
    };

    localparam coefT ffIm [`POLES][`DSR] = '{
        '{-16'sd150, -16'sd90, -16'sd20, 16'sd60, 16'sd130, 16'sd200, 16'sd250, 16'sd290},
        '{16'sd220, 16'sd310, 16'sd360, 16'sd370, 16'sd340, 16'sd270, 16'sd170, 16'sd50},
        '{16'sd480, 16'sd350, 16'sd180, -16'sd20, -16'sd210, -16'sd360, -16'sd450, -16'sd470}
    };

    // Pole factors, already raised to the power DSR
    localparam coefT lfRe [`POLES] = '{16'sd11469, 16'sd8192, 16'sd4096};
    localparam coefT lfIm [`POLES] = '{16'sd4915, -16'sd6554, 16'sd9830};

    // Output weights
    localparam coefT wfRe [`POLES] = '{16'sd6000, 16'sd4500, -16'sd3000};
    localparam coefT wfIm [`POLES] = '{-16'sd2000, 16'sd3000, 16'sd2500};

endpackage

//--- source/hybridDecim_cfg.svh
`ifndef HYBRIDDECIM_CFG_SVH
`define HYBRIDDECIM_CFG_SVH

// Decimation ratio, also the block length in bits
`define DSR 8

// Newest bits seen by the FIR
`define LOOKAHEAD 16

// Complex recursions in the lookback bank
`define POLES 3

// Coefficient format
`define FRAC 14
`define COEF_WIDTH 16

// Sums and pole states
`define ACC_WIDTH 26

// Bits per partial-sum LUT
`define LUT_SIZE 4

// Output word and scaling
`define OUT_WIDTH 14
`define OUT_SHIFT 3

// Cycles from block strobe to valid
`define LATENCY 5
`define WARMUP_BLOCKS 3

`endif
